/* source/cpu_params.svh */
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// Instruction memory, word addressed
`define CPU_IMEM_WORDS 256
`define CPU_IMEM_AW    8

// Data memory, word addressed
`define CPU_DMEM_WORDS 256

`define CPU_RESET_PC   32'h0000_0000

// Integer register file, x0 hardwired to zero
`define CPU_REG_COUNT  32

`endif

/* source/cpu_pkg.sv */
package cpu_pkg;

	// Phases of one instruction
	typedef enum logic [2:0] {
		IDLE  = 3'd0,
		PC    = 3'd1,
		IMR   = 3'd2,
		IDRFR = 3'd3,
		EX    = 3'd4,
		DMRW  = 3'd5
	} cpu_state_t;

	typedef enum logic [2:0] {
		OP_LUI    = 3'd0,
		OP_IMM    = 3'd1,
		OP_REG    = 3'd2,
		OP_LOAD   = 3'd3,
		OP_STORE  = 3'd4,
		OP_BRANCH = 3'd5,
		OP_JAL    = 3'd6,
		OP_NONE   = 3'd7    // Unsupported, retires as nop
	} inst_class_t;

	typedef enum logic [2:0] {
		ALU_ADD   = 3'd0,
		ALU_SUB   = 3'd1,
		ALU_AND   = 3'd2,
		ALU_OR    = 3'd3,
		ALU_XOR   = 3'd4,
		ALU_SLT   = 3'd5,
		ALU_PASSB = 3'd6
	} alu_op_t;

endpackage

/* source/cpu_state_machine.sv */
`timescale 1ns/10ps

module cpu_state_machine (
	input  logic clk,
	input  logic rst_n,
	input  logic stall,
	input  logic imr_run,
	input  logic id_rfr_run,
	input  logic dmrw_run,
	output logic stat_before_exec,
	output logic stat_pc,
	output logic stat_imr,
	output logic stat_idrfr,
	output logic stat_ex,
	output logic stat_dmrw
);
	import cpu_pkg::*;

	cpu_state_t state;
	cpu_state_t next_state;

	always_comb begin
		case (state)
			IDLE:    next_state = stall ? IDLE : PC;
			PC:      next_state = stall ? IDLE : IMR;
			IMR: begin
				if (stall)        next_state = IDLE;
				else if (imr_run) next_state = IMR;   // Fetch still in flight
				else              next_state = IDRFR;
			end
			IDRFR: begin
				if (stall)           next_state = IDLE;
				else if (id_rfr_run) next_state = IDRFR;
				else                 next_state = EX;
			end
			EX:      next_state = stall ? IDLE : DMRW;
			// Stall not honoured here so a store completes
			DMRW:    next_state = dmrw_run ? DMRW : PC;
			default: next_state = IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			state <= IDLE;
		else
			state <= next_state;
	end

	assign stat_pc    = (state == PC);
	assign stat_imr   = (state == IMR);
	assign stat_idrfr = (state == IDRFR);
	assign stat_ex    = (state == EX);
	assign stat_dmrw  = (state == DMRW);

	assign stat_before_exec = stat_pc | stat_imr | stat_idrfr;

endmodule

/* source/inst_mem_read.sv */
`timescale 1ns/10ps
`include "cpu_params.svh"

module inst_mem_read (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    stat_imr,
	input  logic                    imem_we,
	input  logic [`CPU_IMEM_AW-1:0] imem_addr,
	input  logic [31:0]             imem_wdata,
	input  logic [31:0]             pc,
	output logic                    imr_run,
	output logic [31:0]             instr
);

	logic [31:0] imem [0:`CPU_IMEM_WORDS-1];
	logic [31:0] imem_q;    // Synchronous read data
	logic        issued;

	// Busy only in the first IMR cycle
	assign imr_run = stat_imr & ~issued;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			issued <= 1'b0;
		else
			issued <= stat_imr;
	end

	// Load port, used while the core is held in stall
	always_ff @(posedge clk) begin
		if (imem_we)
			imem[imem_addr] <= imem_wdata;
	end

	always_ff @(posedge clk) begin
		if (imr_run)
			imem_q <= imem[pc[`CPU_IMEM_AW+1:2]];
		if (stat_imr && issued)
			instr <= imem_q;    // Instruction register
	end

endmodule

/* source/decode_regfile.sv */
`timescale 1ns/10ps
`include "cpu_params.svh"

module decode_regfile (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 stat_idrfr,
	input  logic [31:0]          instr,
	input  logic                 wb_en,
	input  logic [4:0]           wb_rd,
	input  logic [31:0]          wb_data,
	output logic                 id_rfr_run,
	output logic [31:0]          rs1_val,
	output logic [31:0]          rs2_val,
	output logic [31:0]          imm,
	output logic [4:0]           rd,
	output cpu_pkg::inst_class_t inst_class,
	output cpu_pkg::alu_op_t     alu_op
);
	import cpu_pkg::*;

	logic [31:0] regs [0:`CPU_REG_COUNT-1];
	logic        issued;
	logic [6:0]  opcode;
	logic [2:0]  funct3;
	logic [6:0]  funct7;
	logic [4:0]  rs1;
	logic [4:0]  rs2;

	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];
	assign rs1    = instr[19:15];
	assign rs2    = instr[24:20];
	assign rd     = instr[11:7];

	always_comb begin
		inst_class = OP_NONE;
		alu_op     = ALU_ADD;
		imm        = 32'd0;
		case (opcode)
			7'b0110111: begin    // LUI
				inst_class = OP_LUI;
				alu_op     = ALU_PASSB;
				imm        = {instr[31:12], 12'd0};
			end
			7'b0010011: begin
				imm = {{20{instr[31]}}, instr[31:20]};
				if (funct3 == 3'b000)
					inst_class = OP_IMM;    // ADDI only
			end
			7'b0110011: begin
				inst_class = OP_REG;
				case ({funct7, funct3})
					10'b0000000_000: alu_op = ALU_ADD;
					10'b0100000_000: alu_op = ALU_SUB;
					10'b0000000_111: alu_op = ALU_AND;
					10'b0000000_110: alu_op = ALU_OR;
					10'b0000000_100: alu_op = ALU_XOR;
					10'b0000000_010: alu_op = ALU_SLT;
					default:         inst_class = OP_NONE;
				endcase
			end
			7'b0000011: begin
				imm = {{20{instr[31]}}, instr[31:20]};
				if (funct3 == 3'b010)
					inst_class = OP_LOAD;
			end
			7'b0100011: begin
				imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
				if (funct3 == 3'b010)
					inst_class = OP_STORE;
			end
			7'b1100011: begin
				imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
					instr[11:8], 1'b0};
				// BNE is marked by ALU_XOR so exec can invert the compare
				if (funct3 == 3'b000) begin
					inst_class = OP_BRANCH;
					alu_op     = ALU_SUB;
				end else if (funct3 == 3'b001) begin
					inst_class = OP_BRANCH;
					alu_op     = ALU_XOR;
				end
			end
			7'b1101111: begin    // JAL
				inst_class = OP_JAL;
				imm        = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
					instr[30:21], 1'b0};
			end
			default: ;
		endcase
	end

	assign id_rfr_run = stat_idrfr & ~issued;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			issued <= 1'b0;
		else
			issued <= stat_idrfr;
	end

	always_ff @(posedge clk) begin
		if (id_rfr_run) begin
			rs1_val <= (rs1 == 5'd0) ? 32'd0 : regs[rs1];
			rs2_val <= (rs2 == 5'd0) ? 32'd0 : regs[rs2];
		end
		if (wb_en && wb_rd != 5'd0)
			regs[wb_rd] <= wb_data;
	end

endmodule

/* source/exec_pc_unit.sv */
`timescale 1ns/10ps
`include "cpu_params.svh"

module exec_pc_unit (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 stat_ex,
	input  logic                 stat_dmrw,
	input  logic                 dmrw_run,
	input  logic [31:0]          rs1_val,
	input  logic [31:0]          rs2_val,
	input  logic [31:0]          imm,
	input  cpu_pkg::inst_class_t inst_class,
	input  cpu_pkg::alu_op_t     alu_op,
	output logic [31:0]          pc,
	output logic [31:0]          alu_result,
	output logic [31:0]          store_data
);
	import cpu_pkg::*;

	logic [31:0] alu_b;
	logic [31:0] alu_out;
	logic [31:0] pc_plus4;
	logic [31:0] next_pc;
	logic        taken;

	// Register operand for R-type and branch compare, else immediate
	assign alu_b = (inst_class == OP_REG || inst_class == OP_BRANCH) ? rs2_val : imm;

	always_comb begin
		case (alu_op)
			ALU_ADD:   alu_out = rs1_val + alu_b;
			ALU_SUB:   alu_out = rs1_val - alu_b;
			ALU_AND:   alu_out = rs1_val & alu_b;
			ALU_OR:    alu_out = rs1_val | alu_b;
			ALU_XOR:   alu_out = rs1_val ^ alu_b;
			ALU_SLT:   alu_out = {31'd0, $signed(rs1_val) < $signed(alu_b)};
			ALU_PASSB: alu_out = alu_b;
			default:   alu_out = rs1_val + alu_b;
		endcase
	end

	assign pc_plus4 = pc + 32'd4;

	// Zero result means equal for both SUB (BEQ) and XOR (BNE)
	always_comb begin
		if (inst_class == OP_JAL)
			taken = 1'b1;
		else if (inst_class == OP_BRANCH)
			taken = (alu_op == ALU_XOR) ? (alu_out != 32'd0) : (alu_out == 32'd0);
		else
			taken = 1'b0;
	end

	always_ff @(posedge clk) begin
		if (stat_ex) begin
			alu_result <= (inst_class == OP_JAL) ? pc_plus4 : alu_out;    // Link value
			store_data <= rs2_val;
			next_pc    <= taken ? pc + imm : pc_plus4;
		end
	end

	// PC moves only when the instruction retires
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			pc <= `CPU_RESET_PC;
		else if (stat_dmrw && !dmrw_run)
			pc <= next_pc;
	end

endmodule

/* source/data_mem_rw.sv */
`timescale 1ns/10ps
`include "cpu_params.svh"

module data_mem_rw (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 stat_dmrw,
	input  cpu_pkg::inst_class_t inst_class,
	input  logic [31:0]          alu_result,
	input  logic [31:0]          store_data,
	output logic                 dmrw_run,
	output logic [31:0]          wb_data
);
	import cpu_pkg::*;

	localparam int DMEM_AW = $clog2(`CPU_DMEM_WORDS);

	logic [31:0]        dmem [0:`CPU_DMEM_WORDS-1];
	logic [31:0]        load_q;
	logic [DMEM_AW-1:0] word_addr;
	logic               is_mem;
	logic               issued;

	assign word_addr = alu_result[DMEM_AW+1:2];    // Byte address to word index
	assign is_mem    = (inst_class == OP_LOAD) || (inst_class == OP_STORE);

	// Only LW and SW take the extra cycle
	assign dmrw_run = stat_dmrw & is_mem & ~issued;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			issued <= 1'b0;
		else
			issued <= stat_dmrw;
	end

	always_ff @(posedge clk) begin
		if (dmrw_run && inst_class == OP_STORE)
			dmem[word_addr] <= store_data;
		if (dmrw_run && inst_class == OP_LOAD)
			load_q <= dmem[word_addr];
	end

	assign wb_data = (inst_class == OP_LOAD) ? load_q : alu_result;

endmodule

/* source/cpu_top.sv */
`timescale 1ns/10ps
`include "cpu_params.svh"

module cpu_top (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    stall,
	input  logic                    imem_we,
	input  logic [`CPU_IMEM_AW-1:0] imem_addr,
	input  logic [31:0]             imem_wdata,
	output logic                    retire,
	output logic [31:0]             retire_pc,
	output logic                    wb_valid,
	output logic [4:0]              wb_rd,
	output logic [31:0]             wb_data
);
	import cpu_pkg::*;

	logic        stat_before_exec;
	logic        stat_pc;
	logic        stat_imr;
	logic        stat_idrfr;
	logic        stat_ex;
	logic        stat_dmrw;
	logic        imr_run;
	logic        id_rfr_run;
	logic        dmrw_run;
	logic [31:0] instr;
	logic [31:0] pc;
	logic [31:0] rs1_val;
	logic [31:0] rs2_val;
	logic [31:0] imm;
	logic [4:0]  rd;
	inst_class_t inst_class;
	alu_op_t     alu_op;
	logic [31:0] alu_result;
	logic [31:0] store_data;
	logic [31:0] result_data;
	logic        last_dmrw;
	logic        writes_rd;
	logic        rf_we;

	// Final cycle of the instruction
	assign last_dmrw = stat_dmrw & ~dmrw_run;

	assign writes_rd = (inst_class == OP_LUI) || (inst_class == OP_IMM) ||
		(inst_class == OP_REG) || (inst_class == OP_LOAD) || (inst_class == OP_JAL);
	assign rf_we = last_dmrw & writes_rd & (rd != 5'd0);

	cpu_state_machine cpu_state_machine_inst (
		.clk              (clk),
		.rst_n            (rst_n),
		.stall            (stall),
		.imr_run          (imr_run),
		.id_rfr_run       (id_rfr_run),
		.dmrw_run         (dmrw_run),
		.stat_before_exec (stat_before_exec),
		.stat_pc          (stat_pc),
		.stat_imr         (stat_imr),
		.stat_idrfr       (stat_idrfr),
		.stat_ex          (stat_ex),
		.stat_dmrw        (stat_dmrw)
	);

	inst_mem_read inst_mem_read_inst (
		.clk        (clk),
		.rst_n      (rst_n),
		.stat_imr   (stat_imr),
		.imem_we    (imem_we),
		.imem_addr  (imem_addr),
		.imem_wdata (imem_wdata),
		.pc         (pc),
		.imr_run    (imr_run),
		.instr      (instr)
	);

	decode_regfile decode_regfile_inst (
		.clk        (clk),
		.rst_n      (rst_n),
		.stat_idrfr (stat_idrfr),
		.instr      (instr),
		.wb_en      (rf_we),
		.wb_rd      (rd),
		.wb_data    (result_data),
		.id_rfr_run (id_rfr_run),
		.rs1_val    (rs1_val),
		.rs2_val    (rs2_val),
		.imm        (imm),
		.rd         (rd),
		.inst_class (inst_class),
		.alu_op     (alu_op)
	);

	exec_pc_unit exec_pc_unit_inst (
		.clk        (clk),
		.rst_n      (rst_n),
		.stat_ex    (stat_ex),
		.stat_dmrw  (stat_dmrw),
		.dmrw_run   (dmrw_run),
		.rs1_val    (rs1_val),
		.rs2_val    (rs2_val),
		.imm        (imm),
		.inst_class (inst_class),
		.alu_op     (alu_op),
		.pc         (pc),
		.alu_result (alu_result),
		.store_data (store_data)
	);

	data_mem_rw data_mem_rw_inst (
		.clk        (clk),
		.rst_n      (rst_n),
		.stat_dmrw  (stat_dmrw),
		.inst_class (inst_class),
		.alu_result (alu_result),
		.store_data (store_data),
		.dmrw_run   (dmrw_run),
		.wb_data    (result_data)
	);

	// Trace strobes
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			retire   <= 1'b0;
			wb_valid <= 1'b0;
		end else begin
			retire   <= last_dmrw;
			wb_valid <= rf_we;
		end
	end

	// PC still holds the retiring instruction here
	always_ff @(posedge clk) begin
		if (last_dmrw) begin
			retire_pc <= pc;
			wb_rd     <= rd;
			wb_data   <= result_data;
		end
	end

endmodule

/* sim/tb_clock.sv */
`timescale 1ns/10ps

module tb_clock (
	output logic clk,
	output logic rst_n
);

	initial clk = 1'b0;
	always #4 clk = ~clk;    // 8 ns period

	initial begin
		rst_n = 1'b0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
	end

endmodule

/* sim/cpu_asserts.sv */
`timescale 1ns/10ps

module cpu_asserts (
	input logic clk,
	input logic rst_n,
	input logic stall,
	input logic stat_before_exec,
	input logic stat_pc,
	input logic stat_imr,
	input logic stat_idrfr,
	input logic stat_ex,
	input logic stat_dmrw,
	input logic retire,
	input logic wb_valid
);

	logic abortable;
	logic any_phase;

	assign abortable = stat_before_exec | stat_ex;
	assign any_phase = stat_pc | stat_imr | stat_idrfr | stat_ex | stat_dmrw;

	onehot_phase: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0({stat_pc, stat_imr, stat_idrfr, stat_ex, stat_dmrw}))
		else $error("more than one phase flag high");

	// No phase flag means IDLE
	stall_to_idle: assert property (@(posedge clk) disable iff (!rst_n)
		(stall && abortable) |=> !any_phase)
		else $error("stall did not return the FSM to idle");

	retire_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		retire |=> !retire)
		else $error("retire held for more than one cycle");

	wb_with_retire: assert property (@(posedge clk) disable iff (!rst_n)
		wb_valid |-> retire)
		else $error("wb_valid without retire");

endmodule

bind cpu_top cpu_asserts cpu_asserts_inst (
	.clk              (clk),
	.rst_n            (rst_n),
	.stall            (stall),
	.stat_before_exec (stat_before_exec),
	.stat_pc          (stat_pc),
	.stat_imr         (stat_imr),
	.stat_idrfr       (stat_idrfr),
	.stat_ex          (stat_ex),
	.stat_dmrw        (stat_dmrw),
	.retire           (retire),
	.wb_valid         (wb_valid)
);

/* sim/cpu_tb.sv */
`timescale 1ns/10ps
`include "cpu_params.svh"

module cpu_tb;

	localparam int O_LUI = 0, O_ADDI = 1, O_ADD = 2, O_SUB = 3, O_AND = 4, O_OR = 5;
	localparam int O_XOR = 6, O_SLT = 7, O_LW = 8, O_SW = 9, O_BEQ = 10, O_BNE = 11;
	localparam int O_JAL = 12;

	logic                    clk;
	logic                    rst_n;
	logic                    stall;
	logic                    imem_we;
	logic [`CPU_IMEM_AW-1:0] imem_addr;
	logic [31:0]             imem_wdata;
	logic                    retire;
	logic [31:0]             retire_pc;
	logic                    wb_valid;
	logic [4:0]              wb_rd;
	logic [31:0]             wb_data;

	logic [31:0] lfsr = 32'h8f47610b;
	logic [31:0] arith_seed;
	int          err_cnt = 0;
	bit          aborted = 0;

	// Program image and its fields for the reference model
	int          p_len;
	int          p_op [64];
	logic [4:0]  p_rd [64];
	logic [4:0]  p_rs1 [64];
	logic [4:0]  p_rs2 [64];
	logic [31:0] p_imm [64];
	logic [31:0] p_word [64];

	logic [31:0] mregs [32];
	logic [31:0] mdmem [256];

	logic [31:0] exp_pc[$], exp_data[$], act_pc[$], act_data[$], ref_pc[$], ref_data[$];
	logic [4:0]  exp_rd[$], act_rd[$], ref_rd[$];
	bit          exp_wb[$];
	int          exp_len[$];

	tb_clock tb_clock_inst (.clk(clk), .rst_n(rst_n));

	cpu_top cpu_top_inst (
		.clk        (clk),
		.rst_n      (rst_n),
		.stall      (stall),
		.imem_we    (imem_we),
		.imem_addr  (imem_addr),
		.imem_wdata (imem_wdata),
		.retire     (retire),
		.retire_pc  (retire_pc),
		.wb_valid   (wb_valid),
		.wb_rd      (wb_rd),
		.wb_data    (wb_data)
	);

	// Galois LFSR stepped once per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = 32'd0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
		end
		return v;
	endfunction

	// Random LUI operand in the upper 20 bits
	function automatic logic [31:0] upper_operand();
		logic [31:0] r;
		r = rand_bits(20);
		return {r[19:0], 12'h000};
	endfunction

	// Random I-type immediate, sign extended from bit 11
	function automatic logic [31:0] signed_imm12();
		logic [31:0] r;
		r = rand_bits(12);
		return {{20{r[11]}}, r[11:0]};
	endfunction

	function automatic logic [31:0] encode(input int op, input logic [4:0] rd,
		input logic [4:0] rs1, input logic [4:0] rs2, input logic [31:0] imm);
		case (op)
			O_LUI:  return {imm[31:12], rd, 7'h37};
			O_ADDI: return {imm[11:0], rs1, 3'b000, rd, 7'h13};
			O_ADD:  return {7'h00, rs2, rs1, 3'b000, rd, 7'h33};
			O_SUB:  return {7'h20, rs2, rs1, 3'b000, rd, 7'h33};
			O_AND:  return {7'h00, rs2, rs1, 3'b111, rd, 7'h33};
			O_OR:   return {7'h00, rs2, rs1, 3'b110, rd, 7'h33};
			O_XOR:  return {7'h00, rs2, rs1, 3'b100, rd, 7'h33};
			O_SLT:  return {7'h00, rs2, rs1, 3'b010, rd, 7'h33};
			O_LW:   return {imm[11:0], rs1, 3'b010, rd, 7'h03};
			O_SW:   return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'h23};
			O_BEQ:  return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], 7'h63};
			O_BNE:  return {imm[12], imm[10:5], rs2, rs1, 3'b001, imm[4:1], imm[11], 7'h63};
			default: return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
		endcase
	endfunction

	task automatic put(input int op, input logic [4:0] rd, input logic [4:0] rs1,
		input logic [4:0] rs2, input logic [31:0] imm);
		p_op[p_len]   = op;
		p_rd[p_len]   = rd;
		p_rs1[p_len]  = rs1;
		p_rs2[p_len]  = rs2;
		p_imm[p_len]  = imm;
		p_word[p_len] = encode(op, rd, rs1, rs2, imm);
		p_len++;
	endtask

	task automatic close_program();
		put(O_JAL, 5'd0, 5'd0, 5'd0, -(p_len * 4));    // Loop back to the reset PC
	endtask

	task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp) begin
			err_cnt++;
			$display("FAIL %s: expected %h, got %h", name, exp, act);
		end
	endtask

	// ISA-level model that runs the program until it returns to the reset PC
	task automatic run_model();
		logic [31:0] mpc, npc, a, b, res, addr;
		logic        wr;
		int          i, steps;
		exp_pc.delete();
		exp_rd.delete();
		exp_data.delete();
		exp_wb.delete();
		exp_len.delete();
		mpc = `CPU_RESET_PC;
		steps = 0;
		do begin
			i    = mpc >> 2;
			a    = mregs[p_rs1[i]];
			b    = mregs[p_rs2[i]];
			addr = a + p_imm[i];
			npc  = mpc + 32'd4;
			wr   = 1'b1;
			res  = 32'd0;
			case (p_op[i])
				O_LUI:  res = p_imm[i];
				O_ADDI: res = addr;
				O_ADD:  res = a + b;
				O_SUB:  res = a - b;
				O_AND:  res = a & b;
				O_OR:   res = a | b;
				O_XOR:  res = a ^ b;
				O_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
				O_LW:   res = mdmem[addr[9:2]];
				O_SW: begin
					mdmem[addr[9:2]] = b;
					wr = 1'b0;
				end
				O_BEQ: begin
					wr = 1'b0;
					if (a == b) npc = mpc + p_imm[i];
				end
				O_BNE: begin
					wr = 1'b0;
					if (a != b) npc = mpc + p_imm[i];
				end
				default: begin
					res = mpc + 32'd4;
					npc = mpc + p_imm[i];
				end
			endcase
			if (wr && p_rd[i] != 5'd0)
				mregs[p_rd[i]] = res;
			exp_pc.push_back(mpc);
			exp_rd.push_back(p_rd[i]);
			exp_data.push_back(res);
			exp_wb.push_back(wr && p_rd[i] != 5'd0);
			exp_len.push_back((p_op[i] == O_LW || p_op[i] == O_SW) ? 8 : 7);
			mpc = npc;
			steps++;
		end while (mpc != `CPU_RESET_PC && steps < 100);
	endtask

	task automatic load_program();
		for (int i = 0; i < p_len; i++) begin
			@(negedge clk);
			imem_we    = 1'b1;
			imem_addr  = i[`CPU_IMEM_AW-1:0];
			imem_wdata = p_word[i];
		end
		@(negedge clk);
		imem_we = 1'b0;
	endtask

	// Releases stall, checks each retire, holds stall again after the last one
	task automatic run_program(input bit random_stall, input bit check_gap);
		int wcnt, cyc, last_cyc, scnt;
		stall = 1'b1;
		load_program();
		run_model();
		act_pc.delete();
		act_rd.delete();
		act_data.delete();
		@(negedge clk);
		stall = 1'b0;
		cyc = 0;
		last_cyc = -1;
		scnt = 0;
		for (int n = 0; n < exp_pc.size(); n++) begin
			wcnt = 0;
			do begin
				@(negedge clk);
				cyc++;
				wcnt++;
				if (random_stall) begin
					if (scnt > 0) begin
						scnt--;
						stall = (scnt != 0);
					end else if (rand_bits(3) == 0) begin
						stall = 1'b1;
						scnt = 1 + rand_bits(4);
					end
				end
			end while (!retire && wcnt < 400);
			if (!retire) begin
				err_cnt++;
				aborted = 1;
				$display("Timed out waiting for retire %0d", n);
				stall = 1'b1;
				return;
			end
			check_val("retire_pc", exp_pc[n], retire_pc);
			check_val("wb_valid", {31'd0, exp_wb[n]}, {31'd0, wb_valid});
			if (exp_wb[n]) begin
				check_val("wb_rd", {27'd0, exp_rd[n]}, {27'd0, wb_rd});
				check_val("wb_data", exp_data[n], wb_data);
			end
			if (check_gap && last_cyc >= 0)
				check_val("retire gap", exp_len[n], cyc - last_cyc);
			last_cyc = cyc;
			act_pc.push_back(retire_pc);
			act_rd.push_back(wb_rd);
			act_data.push_back(wb_data);
			if (n == exp_pc.size() - 1)
				stall = 1'b1;    // Park in idle at the reset PC
		end
		repeat (3) @(negedge clk);
	endtask

	task automatic test_reset();
		int wcnt;
		wcnt = 0;
		while (!rst_n && wcnt < 20) begin
			@(negedge clk);
			wcnt++;
		end
		if (!rst_n) begin
			err_cnt++;
			aborted = 1;
			$display("Reset never released");
			return;
		end
		repeat (10) begin
			@(negedge clk);
			check_val("retire", 32'd0, {31'd0, retire});
			check_val("wb_valid", 32'd0, {31'd0, wb_valid});
		end
	endtask

	task automatic build_arith();
		lfsr = arith_seed;
		p_len = 0;
		put(O_LUI, 5'd1, 5'd0, 5'd0, upper_operand());
		put(O_ADDI, 5'd1, 5'd1, 5'd0, signed_imm12());
		put(O_LUI, 5'd2, 5'd0, 5'd0, upper_operand());
		put(O_ADDI, 5'd2, 5'd2, 5'd0, signed_imm12());
		put(O_ADDI, 5'd3, 5'd0, 5'd0, signed_imm12());
		put(O_ADD, 5'd4, 5'd1, 5'd2, 32'd0);
		put(O_SUB, 5'd5, 5'd1, 5'd3, 32'd0);
		put(O_AND, 5'd6, 5'd4, 5'd2, 32'd0);
		put(O_OR, 5'd7, 5'd5, 5'd1, 32'd0);
		put(O_XOR, 5'd8, 5'd6, 5'd7, 32'd0);
		put(O_SLT, 5'd9, 5'd1, 5'd2, 32'd0);
		put(O_SLT, 5'd10, 5'd3, 5'd1, 32'd0);
		put(O_ADDI, 5'd0, 5'd1, 5'd0, 32'd5);    // x0 targets give no write-back
		put(O_ADD, 5'd0, 5'd1, 5'd2, 32'd0);
		close_program();
	endtask

	task automatic test_arith();
		arith_seed = lfsr;
		build_arith();
		run_program(0, 1);
		ref_pc = act_pc;
		ref_rd = act_rd;
		ref_data = act_data;
	endtask

	task automatic test_memory();
		p_len = 0;
		put(O_ADDI, 5'd1, 5'd0, 5'd0, 32'h40);
		put(O_ADDI, 5'd2, 5'd0, 5'd0, rand_bits(11));
		put(O_LUI, 5'd3, 5'd0, 5'd0, upper_operand());
		put(O_SW, 5'd0, 5'd1, 5'd2, 32'd0);
		put(O_SW, 5'd0, 5'd1, 5'd3, 32'd8);
		put(O_LW, 5'd4, 5'd1, 5'd0, 32'd0);
		put(O_LW, 5'd5, 5'd1, 5'd0, 32'd8);
		put(O_ADDI, 5'd7, 5'd1, 5'd0, 32'd8);
		put(O_LW, 5'd6, 5'd7, 5'd0, 32'hffff_fff8);    // Same word through another base
		close_program();
		run_program(0, 1);
	endtask

	task automatic test_control();
		p_len = 0;
		put(O_ADDI, 5'd1, 5'd0, 5'd0, 32'd5);
		put(O_ADDI, 5'd2, 5'd0, 5'd0, 32'd5);
		put(O_ADDI, 5'd3, 5'd0, 5'd0, 32'd7);
		put(O_BEQ, 5'd0, 5'd1, 5'd2, 32'd8);     // Taken
		put(O_ADDI, 5'd10, 5'd0, 5'd0, 32'd1);
		put(O_BEQ, 5'd0, 5'd1, 5'd3, 32'd8);
		put(O_BNE, 5'd0, 5'd1, 5'd2, 32'd8);
		put(O_BNE, 5'd0, 5'd1, 5'd3, 32'd8);     // Taken
		put(O_ADDI, 5'd11, 5'd0, 5'd0, 32'd2);
		put(O_JAL, 5'd12, 5'd0, 5'd0, 32'd8);
		put(O_ADDI, 5'd13, 5'd0, 5'd0, 32'd3);
		close_program();
		run_program(0, 1);
	endtask

	task automatic test_stall();
		logic [31:0] saved;
		saved = lfsr;
		build_arith();
		lfsr = saved;
		run_program(1, 0);
		if (act_pc.size() != ref_pc.size()) begin
			err_cnt++;
			$display("Stalled run retired %0d instructions instead of %0d",
				act_pc.size(), ref_pc.size());
			return;
		end
		foreach (ref_pc[i]) begin
			check_val("stalled retire_pc", ref_pc[i], act_pc[i]);
			check_val("stalled wb_rd", {27'd0, ref_rd[i]}, {27'd0, act_rd[i]});
			check_val("stalled wb_data", ref_data[i], act_data[i]);
		end
	endtask

	initial begin
		stall      = 1'b1;
		imem_we    = 1'b0;
		imem_addr  = '0;
		imem_wdata = 32'd0;
		foreach (mregs[i]) mregs[i] = 32'd0;
		test_reset();
		if (!aborted) test_arith();
		if (!aborted) test_memory();
		if (!aborted) test_control();
		if (!aborted) test_stall();
		$display("Errors: %0d", err_cnt);
		if (err_cnt == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

/* filelist.f */
+incdir+source
source/cpu_pkg.sv
source/cpu_state_machine.sv
source/inst_mem_read.sv
source/decode_regfile.sv
source/exec_pc_unit.sv
source/data_mem_rw.sv
source/cpu_top.sv
sim/tb_clock.sv
sim/cpu_asserts.sv
sim/cpu_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f filelist.f --top-module cpu_tb -o cpu_sim

out=$(./obj_dir/cpu_sim)
echo "$out"
echo "$out" | grep -q "^Test OK$"
